// File: Makefile
# Verilator build and run for the pll controller testbench

VERILATOR ?= verilator
TOP       ?= tb_pll_ctrl
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/pll_config.svh
// pll controller register map
// word addresses and reset words
`ifndef PLL_CONFIG_SVH
`define PLL_CONFIG_SVH

// register file size
`define PLL_NUM_WORDS  8

// word addresses
`define PLL_ADDR_PS0   3'd0          // post-scaler 0, pll reset in bit 2
`define PLL_ADDR_PS1   3'd1          // post-scaler 1
`define PLL_ADDR_MUL2  3'd2          // prescale, int mode, mul int/frac
`define PLL_ADDR_SSC3  3'd3          // spread spectrum
`define PLL_ADDR_LDET4 3'd4          // lock window, lf high bits, lock
`define PLL_ADDR_LF5   3'd5          // loop filter low word

// reset words
`define PLL_RST_PS     32'h0008_0000 // bypass set, rest clear
`define PLL_RST_MUL    32'h1800_0280 // prescale 1, integer, mul 40
`define PLL_RST_LDET   32'h0000_0064 // 100 tick lock window
`define PLL_RST_LF     32'h0000_0269 // loop filter default
`define PLL_RST_ZERO   32'h0000_0000 // words 3, 6, 7

// lock readback position in word 4
`define PLL_LOCK_BIT   31

`endif

// File: logic/lock_monitor.sv
// lock monitor
// windowed check that both channels tick
module lock_monitor (
  input  logic   clk,
  input  logic   RSTB,
  input  logic   ref_tick,
  input  logic   tick0,      // channel 0 output
  input  logic   tick1,      // channel 1 output
  pll_cfg_if.mon cfg,
  output logic   lock
);

  logic [8:0] win_cnt_q;  // ref ticks so far in window
  logic       seen0_q;    // channel 0 ticked this window
  logic       seen1_q;
  logic       lock_q;
  logic       clr;        // restart window, drop lock
  logic       win_end;    // last ref tick of window
  logic       ok0;        // channel 0 satisfied or disabled
  logic       ok1;

  assign clr     = cfg.cfg_wr | ~cfg.pll_rstn;
  assign win_end = ref_tick & (({1'b0, win_cnt_q} + 10'd1) >= {1'b0, cfg.ldet_len});

  // a tick in the closing cycle still counts
  assign ok0 = ~cfg.ps0.en | seen0_q | tick0;
  assign ok1 = ~cfg.ps1.en | seen1_q | tick1;

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      win_cnt_q <= '0;
      seen0_q   <= 1'b0;
      seen1_q   <= 1'b0;
      lock_q    <= 1'b0;
    end else if (clr) begin
      win_cnt_q <= '0;                   // config touched, start over
      seen0_q   <= 1'b0;
      seen1_q   <= 1'b0;
      lock_q    <= 1'b0;
    end else if (win_end) begin
      win_cnt_q <= '0;
      seen0_q   <= 1'b0;
      seen1_q   <= 1'b0;
      lock_q    <= ok0 & ok1;            // re-judged every window
    end else begin
      if (ref_tick) begin
        win_cnt_q <= win_cnt_q + 9'd1;
      end
      seen0_q <= seen0_q | tick0;
      seen1_q <= seen1_q | tick1;
    end
  end

  // pll reset forces lock low at once
  assign lock = lock_q & cfg.pll_rstn;

endmodule

// File: logic/pll_cfg_if.sv
// decoded configuration bundle
// register file to channels and lock monitor
interface pll_cfg_if;
  import pll_pkg::*;

  ps_cfg_t    ps0;       // channel 0 word
  ps_cfg_t    ps1;       // channel 1 word
  logic [8:0] ldet_len;  // lock window length
  logic       pll_rstn;  // word 0 bit 2, low holds everything
  logic       cfg_wr;    // pulse per write to words 0..3

  // register file side
  modport regs (
    output ps0, ps1, ldet_len, pll_rstn, cfg_wr
  );

  // post-scaler side
  modport chan (
    input ps0, ps1, pll_rstn
  );

  // lock monitor, only the en bits of ps0/ps1 are looked at
  modport mon (
    input ps0, ps1, ldet_len, pll_rstn, cfg_wr
  );

endinterface

// File: logic/pll_cfg_regs.sv
// configuration register file
// strobe bus access and lock readback
`include "pll_config.svh"

module pll_cfg_regs (
  input  logic               clk,
  input  logic               RSTB,
  input  logic               cfg_req,  // held until ack seen
  input  logic               cfg_web,  // 0 write, 1 read
  input  pll_pkg::cfg_addr_t cfg_ad,
  input  logic [31:0]        cfg_d,
  input  logic               lock,     // from lock monitor
  output logic               cfg_ack,
  output logic [31:0]        cfg_q,
  pll_cfg_if.regs            cfg
);
  import pll_pkg::*;

  cfg_word_u word_q [`PLL_NUM_WORDS];  // stored words
  cfg_word_u rd_word;                  // read mux, lock merged in
  logic      wr_en;                    // write strobe, every held cycle
  logic      wr_first;                 // first cycle of a write request
  logic      ps_wr;                    // write lands in words 0..3
  logic      cfg_wr_q;

  // per-address reset word
  function automatic cfg_word_u rst_word(input cfg_addr_t ad);
    cfg_word_u w;
    case (ad)
      `PLL_ADDR_PS0,
      `PLL_ADDR_PS1:   w.raw = `PLL_RST_PS;
      `PLL_ADDR_MUL2:  w.raw = `PLL_RST_MUL;
      `PLL_ADDR_LDET4: w.raw = `PLL_RST_LDET;
      `PLL_ADDR_LF5:   w.raw = `PLL_RST_LF;
      default:         w.raw = `PLL_RST_ZERO;  // ssc and spare words
    endcase
    return w;
  endfunction

  assign wr_en    = cfg_req & ~cfg_web;
  assign wr_first = wr_en & ~cfg_ack;       // ack still low on first edge
  assign ps_wr    = (cfg_ad <= `PLL_ADDR_SSC3);

  // read data, bit 31 of word 4 is live lock
  always_comb begin
    rd_word = word_q[cfg_ad];
    if (cfg_ad == `PLL_ADDR_LDET4) begin
      rd_word.raw[`PLL_LOCK_BIT] = lock;
    end
  end

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      for (int i = 0; i < `PLL_NUM_WORDS; i++) begin
        word_q[i] <= rst_word(cfg_addr_t'(i));
      end
      cfg_ack  <= 1'b0;
      cfg_q    <= '0;
      cfg_wr_q <= 1'b0;
    end else begin
      cfg_ack  <= cfg_req;                // one cycle behind req, both edges
      cfg_wr_q <= wr_first & ps_wr;       // one pulse per write request
      if (wr_en) begin
        word_q[cfg_ad].raw <= cfg_d;      // held req rewrites same value
      end
      if (cfg_req && cfg_web) begin
        cfg_q <= rd_word.raw;             // valid from ack rise on
      end
    end
  end

  // field decode through the union views
  assign cfg.ps0      = word_q[`PLL_ADDR_PS0].ps;
  assign cfg.ps1      = word_q[`PLL_ADDR_PS1].ps;
  assign cfg.pll_rstn = word_q[`PLL_ADDR_PS0].ps.rstn;
  assign cfg.ldet_len = word_q[`PLL_ADDR_LDET4].ldet.ldet_len;
  assign cfg.cfg_wr   = cfg_wr_q;

endmodule

// File: logic/pll_ctrl_top.sv
// pll configuration and clocking controller
// register file, two post-scalers, lock monitor
module pll_ctrl_top (
  input  logic               clk,
  input  logic               RSTB,
  // config strobe bus
  input  logic               cfg_req,
  input  logic               cfg_web,
  input  pll_pkg::cfg_addr_t cfg_ad,
  input  logic [31:0]        cfg_d,
  output logic               cfg_ack,
  output logic [31:0]        cfg_q,
  // reference edge strobe
  input  logic               ref_tick,
  // outputs
  output logic               out0_tick,
  output logic               out1_tick,
  output logic               lock
);

  pll_cfg_if cfg_bus ();  // decoded fields

  pll_cfg_regs u_regs (
    .clk     (clk),
    .RSTB    (RSTB),
    .cfg_req (cfg_req),
    .cfg_web (cfg_web),
    .cfg_ad  (cfg_ad),
    .cfg_d   (cfg_d),
    .lock    (lock),       // readback in word 4
    .cfg_ack (cfg_ack),
    .cfg_q   (cfg_q),
    .cfg     (cfg_bus)
  );

  // channel 0
  post_scaler u_ps0 (
    .clk      (clk),
    .RSTB     (RSTB),
    .ref_tick (ref_tick),
    .ps       (cfg_bus.ps0),
    .pll_rstn (cfg_bus.pll_rstn),
    .out_tick (out0_tick)
  );

  // channel 1, shares word 0 pll reset
  post_scaler u_ps1 (
    .clk      (clk),
    .RSTB     (RSTB),
    .ref_tick (ref_tick),
    .ps       (cfg_bus.ps1),
    .pll_rstn (cfg_bus.pll_rstn),
    .out_tick (out1_tick)
  );

  lock_monitor u_mon (
    .clk      (clk),
    .RSTB     (RSTB),
    .ref_tick (ref_tick),
    .tick0    (out0_tick),
    .tick1    (out1_tick),
    .cfg      (cfg_bus),
    .lock     (lock)
  );

endmodule

// File: logic/pll_pkg.sv
// pll controller types
// register word layouts
package pll_pkg;

  // word address on the config bus
  typedef logic [2:0] cfg_addr_t;

  // post-scaler word, msb first here
  // bit 0 upward: l1, rstn, spare, l2, l2_frac, en, bypass, pad
  typedef struct packed {
    logic [11:0] pad;      // [31:20] unused
    logic        bypass;   // [19] ref tick straight through
    logic        en;       // [18] channel enable
    logic [5:0]  l2_frac;  // [17:12] stored only
    logic [7:0]  l2;       // [11:4] second stage, divide by l2+1
    logic        spare;    // [3] dummy bit
    logic        rstn;     // [2] pll reset, word 0 only
    logic [1:0]  l1;       // [1:0] first stage, divide by 2**l1
  } ps_cfg_t;

  // word 4 layout
  typedef struct packed {
    logic        lock_ro;  // [31] reads back lock
    logic [18:0] pad;      // [30:12]
    logic [2:0]  lf_hi;    // [11:9] loop filter bits 34:32
    logic [8:0]  ldet_len; // [8:0] window in ref ticks
  } ldet_cfg_t;

  // one stored word, seen as bus data or as fields
  typedef union packed {
    logic [31:0] raw;      // bus view
    ps_cfg_t     ps;       // words 0 and 1
    ldet_cfg_t   ldet;     // word 4
  } cfg_word_u;

endpackage

// File: logic/post_scaler.sv
// output channel post-scaler
// two-stage divider of reference ticks
module post_scaler (
  input  logic             clk,
  input  logic             RSTB,
  input  logic             ref_tick,  // one per reference edge
  input  pll_pkg::ps_cfg_t ps,
  input  logic             pll_rstn,
  output logic             out_tick
);

  logic [2:0] c1_q;        // first stage count
  logic [7:0] c2_q;        // second stage count
  logic [9:0] div_q;       // previous {l1, l2}
  logic [2:0] c1_max;      // terminal count of stage 1
  logic       run;         // enabled and out of pll reset
  logic       cfg_chg;     // divide setting just changed
  logic       carry1;      // stage 1 wraps
  logic       period_end;  // full 2**l1 * (l2+1) period done

  assign run     = ps.en & pll_rstn;
  assign cfg_chg = ({ps.l1, ps.l2} != div_q);

  // 2**l1 - 1 as a thermometer, 000/001/011/111
  assign c1_max = {ps.l1 == 2'd3, ps.l1 >= 2'd2, ps.l1 != 2'd0};

  assign carry1     = ref_tick & (c1_q == c1_max);
  assign period_end = carry1 & (c2_q >= ps.l2);  // >= guards a lowered l2

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      c1_q     <= '0;
      c2_q     <= '0;
      div_q    <= '0;
      out_tick <= 1'b0;
    end else begin
      div_q <= {ps.l1, ps.l2};
      if (!run || cfg_chg || ps.bypass) begin
        c1_q <= '0;                       // fresh period on any change
        c2_q <= '0;
      end else if (ref_tick) begin
        c1_q <= carry1 ? 3'd0 : c1_q + 3'd1;
        if (carry1) begin
          c2_q <= period_end ? 8'd0 : c2_q + 8'd1;
        end
      end
      // same register for bypass and divided path
      out_tick <= run & (ps.bypass ? ref_tick : (period_end & ~cfg_chg));
    end
  end

endmodule

// File: tests/pll_ctrl_properties.sv
// bus and tick protocol checks
// bound into the controller top level
module pll_ctrl_properties (
  input logic clk,
  input logic RSTB,
  input logic cfg_req,
  input logic cfg_ack,
  input logic ref_tick,
  input logic out0_tick,
  input logic out1_tick,
  input logic lock,
  input logic pll_rstn     // word 0 bit 2, from the decode bundle
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack only follows a sampled request
  ack_after_req: assert property (@(posedge clk) disable iff (!RSTB)
    $rose(cfg_ack) |-> $past(cfg_req))
    else $error("cfg_ack rose without a request in the cycle before");

  ack_drops: assert property (@(posedge clk) disable iff (!RSTB)
    !cfg_req |=> !cfg_ack)
    else $error("cfg_ack still high one cycle after cfg_req fell");

  // strobes never stretch past one cycle
  ref_single: assert property (@(posedge clk) disable iff (!RSTB)
    ref_tick |=> !ref_tick)
    else $error("ref_tick held high for more than one cycle");

  out0_single: assert property (@(posedge clk) disable iff (!RSTB)
    out0_tick |=> !out0_tick)
    else $error("out0_tick held high for more than one cycle");

  out1_single: assert property (@(posedge clk) disable iff (!RSTB)
    out1_tick |=> !out1_tick)
    else $error("out1_tick held high for more than one cycle");

  // low in pll reset and still low the cycle it lifts
  lock_in_rst: assert property (@(posedge clk) disable iff (!RSTB)
    !pll_rstn |-> !lock ##1 !lock)
    else $error("lock high during or right after the pll reset bit was low");

endmodule

bind pll_ctrl_top pll_ctrl_properties i_props (
  .clk       (clk),
  .RSTB      (RSTB),
  .cfg_req   (cfg_req),
  .cfg_ack   (cfg_ack),
  .ref_tick  (ref_tick),
  .out0_tick (out0_tick),
  .out1_tick (out1_tick),
  .lock      (lock),
  .pll_rstn  (cfg_bus.pll_rstn)
);

// File: tests/pll_stimulus.txt
# W <word> <data hex>   R <word> <expected hex>
# T <ref ticks> <out0 ticks> <out1 ticks> <lock>, all decimal
R 0 00080000
R 1 00080000
R 2 18000280
R 3 00000000
R 4 00000064
R 5 00000269
R 6 00000000
R 7 00000000
W 3 a5a5a5a5
R 3 a5a5a5a5
W 6 12345678
R 6 12345678
W 4 80000008
R 4 00000008
W 0 00040004
T 10 10 0 1
W 0 00040025
T 20 3 0 1
W 0 00040024
T 10 3 0 1
W 0 00040047
T 45 1 0 0
W 0 00040024
W 1 000c0000
T 20 6 20 1
R 4 80000008
W 2 18000280
R 4 00000008
T 16 6 16 1
W 1 00080000
T 10 3 0 1
W 0 00040020
T 10 0 0 0
R 0 00040020
W 0 00040024
T 12 4 0 1

// File: tests/tb_pll_ctrl.sv
// pll controller testbench
// file-driven bus, tick count and lock checks
`include "pll_config.svh"

module tb_pll_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import pll_pkg::*;

  localparam int    MAX_GAP   = 4;                        // idle cycles between ref ticks
  localparam string STIM_FILE = "tests/pll_stimulus.txt";

  logic        clk;
  logic        RSTB;
  logic        cfg_req;
  logic        cfg_web;
  cfg_addr_t   cfg_ad;
  logic [31:0] cfg_d;
  logic        ref_tick;
  logic        cfg_ack;
  logic [31:0] cfg_q;
  logic        out0_tick;
  logic        out1_tick;
  logic        lock;

  logic [15:0] cnt0 = '0;         // free-running output tick counts
  logic [15:0] cnt1 = '0;
  int          n_checks  = 0;
  int          err_word  = 0;
  int          err_count = 0;
  int          err_bit   = 0;
  int          err_other = 0;
  ps_cfg_t     shadow0 = ps_cfg_t'(`PLL_RST_PS);  // model copy of word 0
  ps_cfg_t     shadow1 = ps_cfg_t'(`PLL_RST_PS);
  int          acc0 = 0;           // ref ticks since a fresh divide setting
  int          acc1 = 0;
  byte         rec_op[$];          // parsed records
  logic [31:0] rec_a[$];
  logic [31:0] rec_b[$];
  logic [31:0] rec_c[$];
  logic [31:0] rec_d[$];

  pll_ctrl_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;        // 40 ns
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (out0_tick) cnt0 = cnt0 + 16'd1;
    if (out1_tick) cnt1 = cnt1 + 16'd1;
  end

  task automatic check_word(input string name, input cfg_word_u got, input cfg_word_u exp);
    n_checks++;
    if (got !== exp) begin
      err_word++;
      $display("ERR %0t %s got %08h exp %08h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      err_bit++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // divide rule, 2**l1 * (l2+1), counted from a fresh phase
  function automatic int model_ticks(input ps_cfg_t ps, input logic rstn, input int acc,
                                     input int n);
    int ratio;
    if (!(ps.en && rstn)) return 0;
    if (ps.bypass) return n;
    ratio = (1 << ps.l1) * (int'(ps.l2) + 1);
    return (acc + n) / ratio - acc / ratio;
  endfunction

  function automatic logic [11:0] div_key(input ps_cfg_t ps);
    return {ps.en, ps.bypass, ps.l1, ps.l2};
  endfunction

  // any change of divide, enable or bypass restarts the phase
  task automatic model_write(input cfg_addr_t ad, input logic [31:0] d);
    cfg_word_u w;
    w.raw = d;
    if (ad == `PLL_ADDR_PS0) begin
      if (w.ps.rstn != shadow0.rstn) acc1 = 0;   // pll reset hits both
      if (w.ps.rstn != shadow0.rstn || div_key(w.ps) != div_key(shadow0)) acc0 = 0;
      shadow0 = w.ps;
    end else if (ad == `PLL_ADDR_PS1) begin
      if (div_key(w.ps) != div_key(shadow1)) acc1 = 0;
      shadow1 = w.ps;
    end
  endtask

  task automatic bus_cycle(input logic web, input cfg_addr_t ad, input logic [31:0] d,
                           output logic [31:0] q);
    cfg_req <= 1'b1;
    cfg_web <= web;
    cfg_ad  <= ad;
    cfg_d   <= d;
    @(negedge clk);
    while (!cfg_ack) @(negedge clk);
    q = cfg_q;                     // read data valid with ack
    @(posedge clk);
    cfg_req <= 1'b0;
    @(negedge clk);
    while (cfg_ack) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic run_ticks(input int n, output logic [15:0] c0, output logic [15:0] c1,
                           output logic lk);
    int          gap;
    logic [15:0] base0;
    logic [15:0] base1;
    base0 = cnt0;
    base1 = cnt1;
    for (int i = 0; i < n; i++) begin
      gap = int'($urandom_range(MAX_GAP, 1));
      repeat (gap) @(posedge clk);
      ref_tick <= 1'b1;
      @(posedge clk);
      ref_tick <= 1'b0;
    end
    repeat (2) @(posedge clk);     // last output tick lands
    @(negedge clk);
    lk = lock;
    c0 = cnt0 - base0;
    c1 = cnt1 - base1;
    @(posedge clk);
  endtask

  initial begin
    int          fd;
    int          total_ticks;
    int          m0;
    int          m1;
    longint      limit;
    string       line;
    logic [31:0] f[4];
    logic [31:0] q;
    logic [15:0] c0;
    logic [15:0] c1;
    logic        lk;
    cfg_word_u   got_w;
    cfg_word_u   exp_w;
    void'($urandom(32'h3be4));
    RSTB     <= 1'b0;
    cfg_req  <= 1'b0;
    cfg_web  <= 1'b1;
    cfg_ad   <= '0;
    cfg_d    <= '0;
    ref_tick <= 1'b0;
    total_ticks = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      err_other++;
      $display("cannot open stimulus file %s", STIM_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        f = '{default: '0};
        if (line[0] == "T") begin
          void'($sscanf(line.substr(2, line.len() - 1), "%d %d %d %d", f[0], f[1], f[2], f[3]));
          total_ticks += int'(f[0]);
        end else begin
          void'($sscanf(line.substr(2, line.len() - 1), "%h %h", f[0], f[1]));
        end
        rec_op.push_back(line[0]);
        rec_a.push_back(f[0]);
        rec_b.push_back(f[1]);
        rec_c.push_back(f[2]);
        rec_d.push_back(f[3]);
      end
      $fclose(fd);
    end
    // worst case gaps per tick plus bus and reset overhead
    limit = (longint'(total_ticks) * (MAX_GAP + 1) + rec_op.size() * 12 + 200) * 40;
    fork
      begin
        #(limit);
        $display("watchdog expired at %0t, stimulus did not complete", $time);
        $display("Regression failed");
        $finish;
      end
    join_none
    repeat (8) @(posedge clk);
    RSTB <= 1'b1;
    @(posedge clk);
    foreach (rec_op[i]) begin
      case (rec_op[i])
        "W": begin
          bus_cycle(1'b0, rec_a[i][2:0], rec_b[i], q);
          model_write(rec_a[i][2:0], rec_b[i]);
        end
        "R": begin
          bus_cycle(1'b1, rec_a[i][2:0], '0, q);
          got_w.raw = q;
          exp_w.raw = rec_b[i];
          check_word($sformatf("cfg_q word %0d", rec_a[i]), got_w, exp_w);
        end
        "T": begin
          m0 = model_ticks(shadow0, shadow0.rstn, acc0, int'(rec_a[i]));
          m1 = model_ticks(shadow1, shadow0.rstn, acc1, int'(rec_a[i]));
          run_ticks(int'(rec_a[i]), c0, c1, lk);
          check_count("out0_tick", c0, rec_b[i][15:0]);
          check_count("out0_tick model", c0, 16'(m0));
          check_count("out1_tick", c1, rec_c[i][15:0]);
          check_count("out1_tick model", c1, 16'(m1));
          check_bit("lock", lk, rec_d[i][0]);
          acc0 = (shadow0.en && shadow0.rstn && !shadow0.bypass) ? acc0 + int'(rec_a[i]) : 0;
          acc1 = (shadow1.en && shadow0.rstn && !shadow1.bypass) ? acc1 + int'(rec_a[i]) : 0;
        end
        default: begin
          err_other++;
          $display("unknown stimulus record type %c", rec_op[i]);
        end
      endcase
    end
    $display("checks %0d, errors: word %0d, count %0d, bit %0d, other %0d",
             n_checks, err_word, err_count, err_bit, err_other);
    if (err_word + err_count + err_bit + err_other == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
logic/pll_pkg.sv
logic/pll_cfg_if.sv
logic/pll_cfg_regs.sv
logic/post_scaler.sv
logic/lock_monitor.sv
logic/pll_ctrl_top.sv
tests/pll_ctrl_properties.sv
tests/tb_pll_ctrl.sv
